// File: source/rv_exe_pkg.sv
`default_nettype none

package rv_exe_pkg;

    // data and address width
    localparam int XLEN = 32;

    // alu operation select
    typedef enum logic [3:0]
    {
        alu_add      = 4'd0,
        alu_sub      = 4'd1,
        alu_sll      = 4'd2,
        alu_slt      = 4'd3,
        alu_sltu     = 4'd4,
        alu_xor      = 4'd5,
        alu_srl      = 4'd6,
        alu_sra      = 4'd7,
        alu_or       = 4'd8,
        alu_and      = 4'd9,
        alu_pass_op2 = 4'd10   // lui
    } alu_op_t;

    // first operand source
    typedef enum logic
    {
        op1_reg = 1'b0,
        op1_pc  = 1'b1         // auipc, jal
    } op1_src_t;

    // second operand source
    typedef enum logic [1:0]
    {
        op2_reg   = 2'd0,
        op2_imm_i = 2'd1,
        op2_imm_s = 2'd2,      // store address offset
        op2_imm_j = 2'd3
    } op2_src_t;

    // write-back value source
    typedef enum logic
    {
        res_alu  = 1'b0,
        res_link = 1'b1        // pc + 4 for jal/jalr
    } res_src_t;

    // branch funct3 codes
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

`default_nettype wire

// File: source/rv_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module rv_regfile
#(
    parameter int P_NUM_REGS = 32,
    localparam int LP_IDX_W = $clog2(P_NUM_REGS)
)
(
    input  wire                            i_clk,
    input  wire [LP_IDX_W-1:0]             i_raddr1,
    input  wire [LP_IDX_W-1:0]             i_raddr2,
    input  wire                            i_we,
    input  wire [LP_IDX_W-1:0]             i_waddr,
    input  wire [rv_exe_pkg::XLEN-1:0]     i_wdata,
    output logic [rv_exe_pkg::XLEN-1:0]    o_rdata1,
    output logic [rv_exe_pkg::XLEN-1:0]    o_rdata2
);

    logic [rv_exe_pkg::XLEN-1:0] regs [P_NUM_REGS];

    // x0 reads as zero, same-edge write is bypassed
    function automatic logic [rv_exe_pkg::XLEN-1:0] read_port(
        input logic [LP_IDX_W-1:0] addr
    );
        if (addr == '0)
            return '0;
        else if (i_we && (addr == i_waddr))
            return i_wdata;
        else
            return regs[addr];
    endfunction

    always_ff @(posedge i_clk)
    begin
        if (i_we && (i_waddr != '0))   // x0 never written
            regs[i_waddr] <= i_wdata;
    end

    always_ff @(posedge i_clk)
    begin
        o_rdata1 <= read_port(i_raddr1);
        o_rdata2 <= read_port(i_raddr2);
    end

    a_waddr_range: assert property (
        @(posedge i_clk) i_we |-> (int'(i_waddr) < P_NUM_REGS)
    );

endmodule

`default_nettype wire

// File: source/rv_operand_sel.sv
`timescale 1ns/1ns
`default_nettype none

module rv_operand_sel
#(
    parameter int P_NUM_REGS = 32,
    localparam int LP_IDX_W = $clog2(P_NUM_REGS)
)
(
    input  wire                            i_clk,
    input  wire                            i_rst_n,
    input  wire [LP_IDX_W-1:0]             i_rs1,
    input  wire [LP_IDX_W-1:0]             i_rs2,
    input  wire [LP_IDX_W-1:0]             i_rd,
    input  wire [rv_exe_pkg::XLEN-1:0]     i_imm_i,
    input  wire [rv_exe_pkg::XLEN-1:0]     i_imm_s,
    input  wire [rv_exe_pkg::XLEN-1:0]     i_imm_j,
    input  wire [rv_exe_pkg::XLEN-1:0]     i_pc,
    input  wire rv_exe_pkg::op1_src_t      i_op1_src,
    input  wire rv_exe_pkg::op2_src_t      i_op2_src,
    input  wire rv_exe_pkg::alu_op_t       i_alu_op,
    input  wire rv_exe_pkg::res_src_t      i_res_src,
    input  wire [2:0]                      i_funct3,
    input  wire                            i_reg_write,
    input  wire                            i_inst_store,
    input  wire                            i_inst_branch,
    input  wire                            i_inst_jal,
    input  wire                            i_inst_jalr,
    input  wire [rv_exe_pkg::XLEN-1:0]     i_reg1_data,
    input  wire [rv_exe_pkg::XLEN-1:0]     i_reg2_data,
    output logic [rv_exe_pkg::XLEN-1:0]    o_op1,
    output logic [rv_exe_pkg::XLEN-1:0]    o_op2,
    output logic [rv_exe_pkg::XLEN-1:0]    o_reg_data2,
    output logic [rv_exe_pkg::XLEN-1:0]    o_pc,
    output logic [rv_exe_pkg::XLEN-1:0]    o_pc_target,
    output logic [LP_IDX_W-1:0]            o_rd,
    output rv_exe_pkg::alu_op_t            o_alu_op,
    output rv_exe_pkg::res_src_t           o_res_src,
    output logic [2:0]                     o_funct3,
    output logic                           o_reg_write,
    output logic                           o_store,
    output logic                           o_branch,
    output logic                           o_jal_jalr
);

    logic [LP_IDX_W-1:0]          rs1;
    logic [LP_IDX_W-1:0]          rs2;
    logic [rv_exe_pkg::XLEN-1:0]  imm_i;
    logic [rv_exe_pkg::XLEN-1:0]  imm_s;
    logic [rv_exe_pkg::XLEN-1:0]  imm_j;
    rv_exe_pkg::op1_src_t         op1_src;
    rv_exe_pkg::op2_src_t         op2_src;
    logic                         inst_jal;
    logic                         inst_jalr;
    logic [rv_exe_pkg::XLEN-1:0]  reg_data1;

    // decoded fields
    always_ff @(posedge i_clk)
    begin
        rs1       <= i_rs1;
        rs2       <= i_rs2;
        o_rd      <= i_rd;
        imm_i     <= i_imm_i;
        imm_s     <= i_imm_s;
        imm_j     <= i_imm_j;
        o_pc      <= i_pc;
        op1_src   <= i_op1_src;
        op2_src   <= i_op2_src;
        o_alu_op  <= i_alu_op;
        o_res_src <= i_res_src;
        o_funct3  <= i_funct3;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            o_reg_write <= 1'b0;
            o_store     <= 1'b0;
            o_branch    <= 1'b0;
            inst_jal    <= 1'b0;
            inst_jalr   <= 1'b0;
        end
        else
        begin
            o_reg_write <= i_reg_write;
            o_store     <= i_inst_store;
            o_branch    <= i_inst_branch;
            inst_jal    <= i_inst_jal;
            inst_jalr   <= i_inst_jalr;
        end
    end

    assign reg_data1   = (rs1 != '0) ? i_reg1_data : '0;
    assign o_reg_data2 = (rs2 != '0) ? i_reg2_data : '0;

    // branches also take their offset from the j slot
    assign o_pc_target = inst_jalr ? (reg_data1 + imm_i) : (o_pc + imm_j);
    assign o_jal_jalr  = inst_jal | inst_jalr;

    assign o_op1 = (op1_src == rv_exe_pkg::op1_pc) ? o_pc : reg_data1;

    always_comb
    begin
        case (op2_src)
            rv_exe_pkg::op2_imm_i: o_op2 = imm_i;
            rv_exe_pkg::op2_imm_s: o_op2 = imm_s;
            rv_exe_pkg::op2_imm_j: o_op2 = imm_j;
            default:               o_op2 = o_reg_data2;
        endcase
    end

    a_jal_jalr_excl: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !(inst_jal && inst_jalr)
    );

endmodule

`default_nettype wire

// File: source/rv_alu.sv
`timescale 1ns/1ns
`default_nettype none

module rv_alu
#(
    parameter int P_NUM_REGS = 32,
    localparam int LP_IDX_W = $clog2(P_NUM_REGS)
)
(
    input  wire                            i_clk,
    input  wire                            i_rst_n,
    input  wire [rv_exe_pkg::XLEN-1:0]     i_op1,
    input  wire [rv_exe_pkg::XLEN-1:0]     i_op2,
    input  wire [rv_exe_pkg::XLEN-1:0]     i_reg_data2,
    input  wire [rv_exe_pkg::XLEN-1:0]     i_pc,
    input  wire [rv_exe_pkg::XLEN-1:0]     i_pc_target,
    input  wire [LP_IDX_W-1:0]             i_rd,
    input  wire rv_exe_pkg::alu_op_t       i_alu_op,
    input  wire rv_exe_pkg::res_src_t      i_res_src,
    input  wire [2:0]                      i_funct3,
    input  wire                            i_reg_write,
    input  wire                            i_store,
    input  wire                            i_branch,
    input  wire                            i_jal_jalr,
    output logic                           o_wb_en,
    output logic [LP_IDX_W-1:0]            o_wb_rd,
    output logic [rv_exe_pkg::XLEN-1:0]    o_wb_data,
    output logic                           o_redirect,
    output logic [rv_exe_pkg::XLEN-1:0]    o_redirect_pc,
    output logic                           o_store_en,
    output logic [rv_exe_pkg::XLEN-1:0]    o_store_addr,
    output logic [rv_exe_pkg::XLEN-1:0]    o_store_data,
    output logic [2:0]                     o_store_funct3
);

    logic [rv_exe_pkg::XLEN-1:0] alu_res;
    logic [rv_exe_pkg::XLEN-1:0] link;
    logic [4:0]                  shamt;
    logic                        eq;
    logic                        lt;
    logic                        ltu;
    logic                        br_taken;

    assign shamt = i_op2[4:0];
    assign link  = i_pc + rv_exe_pkg::XLEN'(4);

    always_comb
    begin
        case (i_alu_op)
            rv_exe_pkg::alu_add:      alu_res = i_op1 + i_op2;
            rv_exe_pkg::alu_sub:      alu_res = i_op1 - i_op2;
            rv_exe_pkg::alu_sll:      alu_res = i_op1 << shamt;
            rv_exe_pkg::alu_slt:      alu_res = {{(rv_exe_pkg::XLEN-1){1'b0}}, lt};
            rv_exe_pkg::alu_sltu:     alu_res = {{(rv_exe_pkg::XLEN-1){1'b0}}, ltu};
            rv_exe_pkg::alu_xor:      alu_res = i_op1 ^ i_op2;
            rv_exe_pkg::alu_srl:      alu_res = i_op1 >> shamt;
            rv_exe_pkg::alu_sra:      alu_res = $unsigned($signed(i_op1) >>> shamt);
            rv_exe_pkg::alu_or:       alu_res = i_op1 | i_op2;
            rv_exe_pkg::alu_and:      alu_res = i_op1 & i_op2;
            rv_exe_pkg::alu_pass_op2: alu_res = i_op2;
            default:                  alu_res = '0;
        endcase
    end

    // shared by slt and the branch compare
    assign eq  = (i_op1 == i_op2);
    assign lt  = ($signed(i_op1) < $signed(i_op2));
    assign ltu = (i_op1 < i_op2);

    always_comb
    begin
        case (i_funct3)
            rv_exe_pkg::F3_BEQ:  br_taken = eq;
            rv_exe_pkg::F3_BNE:  br_taken = !eq;
            rv_exe_pkg::F3_BLT:  br_taken = lt;
            rv_exe_pkg::F3_BGE:  br_taken = !lt;
            rv_exe_pkg::F3_BLTU: br_taken = ltu;
            rv_exe_pkg::F3_BGEU: br_taken = !ltu;
            default:             br_taken = 1'b0;   // undefined codes never taken
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            o_wb_en    <= 1'b0;
            o_redirect <= 1'b0;
            o_store_en <= 1'b0;
        end
        else
        begin
            o_wb_en    <= i_reg_write;
            o_redirect <= i_jal_jalr | (i_branch & br_taken);
            o_store_en <= i_store;
        end
    end

    always_ff @(posedge i_clk)
    begin
        o_wb_rd        <= i_rd;
        o_wb_data      <= (i_res_src == rv_exe_pkg::res_link) ? link : alu_res;
        o_redirect_pc  <= i_pc_target;
        o_store_addr   <= alu_res;   // rs1 + imm_s
        o_store_data   <= i_reg_data2;
        o_store_funct3 <= i_funct3;
    end

    a_store_no_wb: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !(i_store && i_reg_write)
    );

endmodule

`default_nettype wire

// File: source/rv_exe_top.sv
`timescale 1ns/1ns
`default_nettype none

module rv_exe_top
#(
    parameter int P_NUM_REGS = 32,
    localparam int LP_IDX_W = $clog2(P_NUM_REGS)
)
(
    input  wire                            i_clk,
    input  wire                            i_rst_n,
    input  wire [LP_IDX_W-1:0]             i_rs1,
    input  wire [LP_IDX_W-1:0]             i_rs2,
    input  wire [LP_IDX_W-1:0]             i_rd,
    input  wire [rv_exe_pkg::XLEN-1:0]     i_imm_i,
    input  wire [rv_exe_pkg::XLEN-1:0]     i_imm_s,
    input  wire [rv_exe_pkg::XLEN-1:0]     i_imm_j,
    input  wire [rv_exe_pkg::XLEN-1:0]     i_pc,
    input  wire rv_exe_pkg::op1_src_t      i_op1_src,
    input  wire rv_exe_pkg::op2_src_t      i_op2_src,
    input  wire rv_exe_pkg::alu_op_t       i_alu_op,
    input  wire rv_exe_pkg::res_src_t      i_res_src,
    input  wire [2:0]                      i_funct3,
    input  wire                            i_reg_write,
    input  wire                            i_inst_store,
    input  wire                            i_inst_branch,
    input  wire                            i_inst_jal,
    input  wire                            i_inst_jalr,
    output logic                           o_wb_en,
    output logic [LP_IDX_W-1:0]            o_wb_rd,
    output logic [rv_exe_pkg::XLEN-1:0]    o_wb_data,
    output logic                           o_redirect,
    output logic [rv_exe_pkg::XLEN-1:0]    o_redirect_pc,
    output logic                           o_store_en,
    output logic [rv_exe_pkg::XLEN-1:0]    o_store_addr,
    output logic [rv_exe_pkg::XLEN-1:0]    o_store_data,
    output logic [2:0]                     o_store_funct3
);

    logic [rv_exe_pkg::XLEN-1:0] reg1_data;
    logic [rv_exe_pkg::XLEN-1:0] reg2_data;
    logic [rv_exe_pkg::XLEN-1:0] op1;
    logic [rv_exe_pkg::XLEN-1:0] op2;
    logic [rv_exe_pkg::XLEN-1:0] reg_data2;
    logic [rv_exe_pkg::XLEN-1:0] pc;
    logic [rv_exe_pkg::XLEN-1:0] pc_target;
    logic [LP_IDX_W-1:0]         rd;
    rv_exe_pkg::alu_op_t         alu_op;
    rv_exe_pkg::res_src_t        res_src;
    logic [2:0]                  funct3;
    logic                        reg_write;
    logic                        store;
    logic                        branch;
    logic                        jal_jalr;

    // read addresses go straight in, data lines up with the registered fields
    rv_regfile #(.P_NUM_REGS(P_NUM_REGS)) rv_regfile_i (
        .i_clk    (i_clk),
        .i_raddr1 (i_rs1),
        .i_raddr2 (i_rs2),
        .i_we     (o_wb_en),
        .i_waddr  (o_wb_rd),
        .i_wdata  (o_wb_data),
        .o_rdata1 (reg1_data),
        .o_rdata2 (reg2_data)
    );

    rv_operand_sel #(.P_NUM_REGS(P_NUM_REGS)) rv_operand_sel_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_rs1         (i_rs1),
        .i_rs2         (i_rs2),
        .i_rd          (i_rd),
        .i_imm_i       (i_imm_i),
        .i_imm_s       (i_imm_s),
        .i_imm_j       (i_imm_j),
        .i_pc          (i_pc),
        .i_op1_src     (i_op1_src),
        .i_op2_src     (i_op2_src),
        .i_alu_op      (i_alu_op),
        .i_res_src     (i_res_src),
        .i_funct3      (i_funct3),
        .i_reg_write   (i_reg_write),
        .i_inst_store  (i_inst_store),
        .i_inst_branch (i_inst_branch),
        .i_inst_jal    (i_inst_jal),
        .i_inst_jalr   (i_inst_jalr),
        .i_reg1_data   (reg1_data),
        .i_reg2_data   (reg2_data),
        .o_op1         (op1),
        .o_op2         (op2),
        .o_reg_data2   (reg_data2),
        .o_pc          (pc),
        .o_pc_target   (pc_target),
        .o_rd          (rd),
        .o_alu_op      (alu_op),
        .o_res_src     (res_src),
        .o_funct3      (funct3),
        .o_reg_write   (reg_write),
        .o_store       (store),
        .o_branch      (branch),
        .o_jal_jalr    (jal_jalr)
    );

    rv_alu #(.P_NUM_REGS(P_NUM_REGS)) rv_alu_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_op1          (op1),
        .i_op2          (op2),
        .i_reg_data2    (reg_data2),
        .i_pc           (pc),
        .i_pc_target    (pc_target),
        .i_rd           (rd),
        .i_alu_op       (alu_op),
        .i_res_src      (res_src),
        .i_funct3       (funct3),
        .i_reg_write    (reg_write),
        .i_store        (store),
        .i_branch       (branch),
        .i_jal_jalr     (jal_jalr),
        .o_wb_en        (o_wb_en),
        .o_wb_rd        (o_wb_rd),
        .o_wb_data      (o_wb_data),
        .o_redirect     (o_redirect),
        .o_redirect_pc  (o_redirect_pc),
        .o_store_en     (o_store_en),
        .o_store_addr   (o_store_addr),
        .o_store_data   (o_store_data),
        .o_store_funct3 (o_store_funct3)
    );

endmodule

`default_nettype wire

// File: dv/tb_rv_exe.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv_exe;

    localparam int NUM_REGS = 32;
    localparam int XLEN     = rv_exe_pkg::XLEN;

    // one issued instruction and what should come out two edges later
    typedef struct packed {
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic [4:0]            rd;
        logic [XLEN-1:0]       imm_i;
        logic [XLEN-1:0]       imm_s;
        logic [XLEN-1:0]       imm_j;
        logic [XLEN-1:0]       pc;
        rv_exe_pkg::op1_src_t  op1_src;
        rv_exe_pkg::op2_src_t  op2_src;
        rv_exe_pkg::alu_op_t   alu_op;
        rv_exe_pkg::res_src_t  res_src;
        logic [2:0]            funct3;
        logic                  reg_write;
        logic                  store;
        logic                  branch;
        logic                  jal;
        logic                  jalr;
        logic                  exp_wb;
        logic                  exp_redirect;
        logic                  exp_store;
        logic [XLEN-1:0]       exp_wb_data;
        logic [XLEN-1:0]       exp_target;
        logic [XLEN-1:0]       exp_addr;
        logic [XLEN-1:0]       exp_data;
    } row_t;

    logic                  i_clk;
    logic                  i_rst_n;
    logic [4:0]            i_rs1;
    logic [4:0]            i_rs2;
    logic [4:0]            i_rd;
    logic [XLEN-1:0]       i_imm_i;
    logic [XLEN-1:0]       i_imm_s;
    logic [XLEN-1:0]       i_imm_j;
    logic [XLEN-1:0]       i_pc;
    rv_exe_pkg::op1_src_t  i_op1_src;
    rv_exe_pkg::op2_src_t  i_op2_src;
    rv_exe_pkg::alu_op_t   i_alu_op;
    rv_exe_pkg::res_src_t  i_res_src;
    logic [2:0]            i_funct3;
    logic                  i_reg_write;
    logic                  i_inst_store;
    logic                  i_inst_branch;
    logic                  i_inst_jal;
    logic                  i_inst_jalr;
    logic                  o_wb_en;
    logic [4:0]            o_wb_rd;
    logic [XLEN-1:0]       o_wb_data;
    logic                  o_redirect;
    logic [XLEN-1:0]       o_redirect_pc;
    logic                  o_store_en;
    logic [XLEN-1:0]       o_store_addr;
    logic [XLEN-1:0]       o_store_data;
    logic [2:0]            o_store_funct3;

    row_t  rows[$];
    string names[$];
    int    cycles      = 0;
    int    cycle_limit = 0;

    rv_exe_top #(.P_NUM_REGS(NUM_REGS)) rv_exe_top_i (.*);

    always #20 i_clk = ~i_clk;

    always @(posedge i_clk)
    begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit)
        begin
            $display("run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input string what,
        input logic [XLEN-1:0] exp_val, input logic [XLEN-1:0] act);
        if (act !== exp_val)
        begin
            $display("FAILED %s: %s expected 0x%08h, actual 0x%08h", name, what, exp_val, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input string what,
        input logic exp_val, input logic act);
        if (act !== exp_val)
        begin
            $display("FAILED %s: %s expected %b, actual %b", name, what, exp_val, act);
            abort_run();
        end
    endtask

    task automatic check_funct3(input string name, input logic [2:0] exp_val,
        input logic [2:0] act);
        if (act !== exp_val)
        begin
            $display("FAILED %s: store funct3 expected %b, actual %b", name, exp_val, act);
            abort_run();
        end
    endtask

    task automatic check_reg_index(input string name, input logic [4:0] exp_val,
        input logic [4:0] act);
        if (act !== exp_val)
        begin
            $display("FAILED %s: wb_rd expected x%0d, actual x%0d", name, exp_val, act);
            abort_run();
        end
    endtask

    task automatic check_idle(input string name);
        check_bit(name, "wb_en", 1'b0, o_wb_en);
        check_bit(name, "redirect", 1'b0, o_redirect);
        check_bit(name, "store_en", 1'b0, o_store_en);
    endtask

    // strobes low, immediates random
    task automatic drive_bubble();
        i_rs1         <= '0;
        i_rs2         <= '0;
        i_rd          <= '0;
        i_imm_i       <= $urandom();
        i_imm_s       <= $urandom();
        i_imm_j       <= $urandom();
        i_pc          <= '0;
        i_op1_src     <= rv_exe_pkg::op1_reg;
        i_op2_src     <= rv_exe_pkg::op2_reg;
        i_alu_op      <= rv_exe_pkg::alu_add;
        i_res_src     <= rv_exe_pkg::res_alu;
        i_funct3      <= '0;
        i_reg_write   <= 1'b0;
        i_inst_store  <= 1'b0;
        i_inst_branch <= 1'b0;
        i_inst_jal    <= 1'b0;
        i_inst_jalr   <= 1'b0;
    endtask

    task automatic drive_row(input row_t r);
        i_rs1         <= r.rs1;
        i_rs2         <= r.rs2;
        i_rd          <= r.rd;
        i_imm_i       <= r.imm_i;
        i_imm_s       <= r.imm_s;
        i_imm_j       <= r.imm_j;
        i_pc          <= r.pc;
        i_op1_src     <= r.op1_src;
        i_op2_src     <= r.op2_src;
        i_alu_op      <= r.alu_op;
        i_res_src     <= r.res_src;
        i_funct3      <= r.funct3;
        i_reg_write   <= r.reg_write;
        i_inst_store  <= r.store;
        i_inst_branch <= r.branch;
        i_inst_jal    <= r.jal;
        i_inst_jalr   <= r.jalr;
    endtask

    // issue, two bubbles, then outputs of the issued slot are stable
    task automatic apply_row(input string name, input row_t r);
        @(posedge i_clk);
        drive_row(r);
        @(posedge i_clk);
        drive_bubble();
        @(posedge i_clk);
        drive_bubble();
        @(negedge i_clk);
        check_bit(name, "wb_en", r.exp_wb, o_wb_en);
        if (r.exp_wb)
        begin
            check_reg_index(name, r.rd, o_wb_rd);
            check_word(name, "wb_data", r.exp_wb_data, o_wb_data);
        end
        check_bit(name, "redirect", r.exp_redirect, o_redirect);
        if (r.exp_redirect)
            check_word(name, "redirect_pc", r.exp_target, o_redirect_pc);
        check_bit(name, "store_en", r.exp_store, o_store_en);
        if (r.exp_store)
        begin
            check_word(name, "store_addr", r.exp_addr, o_store_addr);
            check_word(name, "store_data", r.exp_data, o_store_data);
            check_funct3(name, r.funct3, o_store_funct3);
        end
    endtask

    task automatic add_rr(input string name, input logic [4:0] rd, input logic [4:0] rs1,
        input logic [4:0] rs2, input rv_exe_pkg::alu_op_t op, input logic [XLEN-1:0] res);
        row_t r;
        r             = '0;
        r.rd          = rd;
        r.rs1         = rs1;
        r.rs2         = rs2;
        r.alu_op      = op;
        r.reg_write   = 1'b1;
        r.exp_wb      = 1'b1;
        r.exp_wb_data = res;
        names.push_back(name);
        rows.push_back(r);
    endtask

    task automatic add_ri(input string name, input logic [4:0] rd, input logic [4:0] rs1,
        input logic [XLEN-1:0] imm, input rv_exe_pkg::alu_op_t op,
        input logic [XLEN-1:0] res);
        row_t r;
        r             = '0;
        r.rd          = rd;
        r.rs1         = rs1;
        r.imm_i       = imm;
        r.op2_src     = rv_exe_pkg::op2_imm_i;
        r.alu_op      = op;
        r.reg_write   = 1'b1;
        r.exp_wb      = 1'b1;
        r.exp_wb_data = res;
        names.push_back(name);
        rows.push_back(r);
    endtask

    // pc 0x200 with offset 0x40 for every branch
    task automatic add_branch(input string name, input logic [2:0] f3,
        input logic [4:0] rs1, input logic [4:0] rs2, input logic taken);
        row_t r;
        r              = '0;
        r.rs1          = rs1;
        r.rs2          = rs2;
        r.funct3       = f3;
        r.pc           = 32'h200;
        r.imm_j        = 32'h40;
        r.branch       = 1'b1;
        r.exp_redirect = taken;
        r.exp_target   = 32'h240;
        names.push_back(name);
        rows.push_back(r);
    endtask

    task automatic add_jump(input string name, input logic is_jalr, input logic [4:0] rd,
        input logic [4:0] rs1, input logic [XLEN-1:0] pc, input logic [XLEN-1:0] imm,
        input logic [XLEN-1:0] target);
        row_t r;
        r              = '0;
        r.rd           = rd;
        r.rs1          = rs1;
        r.pc           = pc;
        r.imm_i        = imm;
        r.imm_j        = imm;
        r.op1_src      = is_jalr ? rv_exe_pkg::op1_reg : rv_exe_pkg::op1_pc;
        r.op2_src      = is_jalr ? rv_exe_pkg::op2_imm_i : rv_exe_pkg::op2_imm_j;
        r.res_src      = rv_exe_pkg::res_link;
        r.reg_write    = 1'b1;
        r.jal          = !is_jalr;
        r.jalr         = is_jalr;
        r.exp_wb       = 1'b1;
        r.exp_wb_data  = pc + 32'd4;   // link
        r.exp_redirect = 1'b1;
        r.exp_target   = target;
        names.push_back(name);
        rows.push_back(r);
    endtask

    task automatic add_store(input string name, input logic [2:0] f3, input logic [4:0] rs1,
        input logic [4:0] rs2, input logic [XLEN-1:0] off, input logic [XLEN-1:0] addr,
        input logic [XLEN-1:0] data);
        row_t r;
        r           = '0;
        r.rs1       = rs1;
        r.rs2       = rs2;
        r.imm_s     = off;
        r.op2_src   = rv_exe_pkg::op2_imm_s;
        r.funct3    = f3;
        r.store     = 1'b1;
        r.exp_store = 1'b1;
        r.exp_addr  = addr;
        r.exp_data  = data;
        names.push_back(name);
        rows.push_back(r);
    endtask

    task automatic build_table();
        row_t r;
        // x1 = 5, x2 = 3, x3 = -8, x4 = 0x80000000
        add_ri("addi x1", 5'd1, 5'd0, 32'd5, rv_exe_pkg::alu_add, 32'd5);
        add_ri("addi x2", 5'd2, 5'd0, 32'd3, rv_exe_pkg::alu_add, 32'd3);
        add_ri("addi x3", 5'd3, 5'd0, 32'hffff_fff8, rv_exe_pkg::alu_add, 32'hffff_fff8);
        add_ri("lui x4", 5'd4, 5'd0, 32'h8000_0000, rv_exe_pkg::alu_pass_op2, 32'h8000_0000);
        add_ri("addi x0", 5'd0, 5'd0, 32'd7, rv_exe_pkg::alu_add, 32'd7);
        add_ri("addi x5 from x0", 5'd5, 5'd0, 32'd1, rv_exe_pkg::alu_add, 32'd1);
        add_rr("add x0 x0", 5'd6, 5'd0, 5'd0, rv_exe_pkg::alu_add, 32'd0);
        add_rr("add", 5'd10, 5'd1, 5'd2, rv_exe_pkg::alu_add, 32'd8);
        add_rr("add dep", 5'd11, 5'd10, 5'd1, rv_exe_pkg::alu_add, 32'd13);
        add_rr("sub", 5'd12, 5'd2, 5'd1, rv_exe_pkg::alu_sub, 32'hffff_fffe);
        add_rr("sll", 5'd12, 5'd1, 5'd2, rv_exe_pkg::alu_sll, 32'h28);
        add_ri("slli shamt wrap", 5'd12, 5'd1, 32'h21, rv_exe_pkg::alu_sll, 32'ha);
        add_rr("slt", 5'd12, 5'd3, 5'd1, rv_exe_pkg::alu_slt, 32'd1);
        add_rr("sltu", 5'd12, 5'd3, 5'd1, rv_exe_pkg::alu_sltu, 32'd0);
        add_ri("slti", 5'd12, 5'd1, 32'hffff_ffff, rv_exe_pkg::alu_slt, 32'd0);
        add_ri("sltiu", 5'd12, 5'd1, 32'hffff_ffff, rv_exe_pkg::alu_sltu, 32'd1);
        add_rr("xor", 5'd12, 5'd1, 5'd2, rv_exe_pkg::alu_xor, 32'd6);
        add_ri("xori", 5'd12, 5'd1, 32'hffff_ffff, rv_exe_pkg::alu_xor, 32'hffff_fffa);
        add_rr("srl", 5'd12, 5'd3, 5'd2, rv_exe_pkg::alu_srl, 32'h1fff_ffff);
        add_rr("sra", 5'd12, 5'd3, 5'd2, rv_exe_pkg::alu_sra, 32'hffff_ffff);
        add_ri("srai", 5'd12, 5'd4, 32'h404, rv_exe_pkg::alu_sra, 32'hf800_0000);
        add_ri("srli", 5'd12, 5'd4, 32'd31, rv_exe_pkg::alu_srl, 32'd1);
        add_rr("or", 5'd12, 5'd1, 5'd2, rv_exe_pkg::alu_or, 32'd7);
        add_ri("ori", 5'd12, 5'd2, 32'h10, rv_exe_pkg::alu_or, 32'h13);
        add_rr("and", 5'd12, 5'd1, 5'd2, rv_exe_pkg::alu_and, 32'd1);
        add_ri("andi", 5'd12, 5'd3, 32'hff, rv_exe_pkg::alu_and, 32'hf8);
        add_ri("lui x13", 5'd13, 5'd0, 32'h1234_5000, rv_exe_pkg::alu_pass_op2, 32'h1234_5000);
        r             = '0;   // auipc x14, 0x1 at pc 0x100
        r.rd          = 5'd14;
        r.pc          = 32'h100;
        r.imm_i       = 32'h1000;
        r.op1_src     = rv_exe_pkg::op1_pc;
        r.op2_src     = rv_exe_pkg::op2_imm_i;
        r.reg_write   = 1'b1;
        r.exp_wb      = 1'b1;
        r.exp_wb_data = 32'h1100;
        names.push_back("auipc");
        rows.push_back(r);
        add_branch("beq taken", rv_exe_pkg::F3_BEQ, 5'd1, 5'd1, 1'b1);
        add_branch("beq not taken", rv_exe_pkg::F3_BEQ, 5'd1, 5'd2, 1'b0);
        add_branch("bne taken", rv_exe_pkg::F3_BNE, 5'd1, 5'd2, 1'b1);
        add_branch("bne not taken", rv_exe_pkg::F3_BNE, 5'd1, 5'd1, 1'b0);
        add_branch("blt taken", rv_exe_pkg::F3_BLT, 5'd3, 5'd1, 1'b1);
        add_branch("blt not taken", rv_exe_pkg::F3_BLT, 5'd1, 5'd3, 1'b0);
        add_branch("bge taken", rv_exe_pkg::F3_BGE, 5'd1, 5'd3, 1'b1);
        add_branch("bge not taken", rv_exe_pkg::F3_BGE, 5'd3, 5'd1, 1'b0);
        add_branch("bltu taken", rv_exe_pkg::F3_BLTU, 5'd1, 5'd3, 1'b1);
        add_branch("bltu not taken", rv_exe_pkg::F3_BLTU, 5'd3, 5'd1, 1'b0);
        add_branch("bgeu taken", rv_exe_pkg::F3_BGEU, 5'd3, 5'd1, 1'b1);
        add_branch("bgeu not taken", rv_exe_pkg::F3_BGEU, 5'd1, 5'd3, 1'b0);
        add_jump("jal fwd", 1'b0, 5'd15, 5'd0, 32'h300, 32'h80, 32'h380);
        add_jump("jal back", 1'b0, 5'd15, 5'd0, 32'h300, 32'hffff_ff00, 32'h200);
        add_jump("jalr x3", 1'b1, 5'd16, 5'd3, 32'h400, 32'h100, 32'hf8);
        add_ri("addi from link", 5'd17, 5'd15, 32'd4, rv_exe_pkg::alu_add, 32'h308);
        add_store("sw", 3'b010, 5'd1, 5'd2, 32'h10, 32'h15, 32'd3);
        add_store("sb", 3'b000, 5'd4, 5'd3, 32'hffff_fffc, 32'h7fff_fffc, 32'hffff_fff8);
    endtask

    initial
    begin
        void'($urandom(17));
        i_clk   = 1'b0;
        i_rst_n = 1'b0;
        drive_bubble();
        build_table();
        cycle_limit = rows.size() * 3 + 20;
        repeat (5) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        check_idle("reset");
        repeat (3)
        begin
            @(posedge i_clk);
            drive_bubble();
            @(negedge i_clk);
            check_idle("random bubble");
        end
        foreach (rows[i])
            apply_row(names[i], rows[i]);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
source/rv_exe_pkg.sv
source/rv_regfile.sv
source/rv_operand_sel.sv
source/rv_alu.sv
source/rv_exe_top.sv
dv/tb_rv_exe.sv

// File: Bender.yml
package:
  name: rv_exe

sources:
  - source/rv_exe_pkg.sv
  - source/rv_regfile.sv
  - source/rv_operand_sel.sv
  - source/rv_alu.sv
  - source/rv_exe_top.sv
  - target: test
    files:
      - dv/tb_rv_exe.sv
